/* src/exec_isa_pkg.sv */
package exec_isa_pkg;

    ////////////////////////////////
    // Operation opcodes
    ////////////////////////////////
    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,   // No operation with all controls low
        OP_ADD  = 5'd1,   // Arithmetic
        OP_SUB  = 5'd2,
        OP_SLT  = 5'd3,   // Signed compare
        OP_SLTU = 5'd4,   // Unsigned compare
        OP_AND  = 5'd5,   // Logic
        OP_OR   = 5'd6,
        OP_XOR  = 5'd7,
        OP_SLL  = 5'd8,   // Shifts
        OP_SRL  = 5'd9,
        OP_SRA  = 5'd10,
        OP_BEQ  = 5'd11,  // Conditional branches
        OP_BNE  = 5'd12,
        OP_BLT  = 5'd13,
        OP_BGE  = 5'd14,
        OP_JAL  = 5'd15,  // Jump and link
        OP_LW   = 5'd16,  // Loads
        OP_LB   = 5'd17,
        OP_SW   = 5'd18,  // Stores
        OP_SB   = 5'd19,
        OP_MOV  = 5'd20   // Operand B bypass
    } exec_op_e;

    ////////////////////////////////
    // Functional units
    ////////////////////////////////
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BRANCH = 2'd1,
        UNIT_MEM    = 2'd2,
        UNIT_BYPASS = 2'd3  // MOV and NOP
    } exec_unit_e;

    localparam int SHAMT_W    = 5;  // Shift amount bits taken from opb
    localparam int INSN_BYTES = 4;  // npc is pc plus one instruction

endpackage

/* src/exec_pipe_pkg.sv */
package exec_pipe_pkg;

    ////////////////////////////////
    // Datapath sizes
    ////////////////////////////////
    localparam int XLEN = 32;       // Data and address width

    localparam int BYTE_W = 8;      // Bits per byte lane

    localparam int BE_W = XLEN / BYTE_W;  // One byte enable per lane

    // Default tag width of the top level
    localparam int TAG_W_DEF = 4;

endpackage

/* src/exec_dispatch.sv */
module exec_dispatch import exec_isa_pkg::*, exec_pipe_pkg::*; #(
    parameter int TAG_W = TAG_W_DEF
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              in_valid_i,    // Operation offered
    input  exec_op_e          in_op_i,
    input  logic [XLEN-1:0]   in_npc_i,
    input  logic [XLEN-1:0]   in_opa_i,
    input  logic [XLEN-1:0]   in_opb_i,
    input  logic [XLEN-1:0]   in_opc_i,
    input  logic [TAG_W-1:0]  in_tag_i,
    input  logic              advance_i,     // Retire takes our entry
    output logic              in_ready_o,
    output logic              disp_valid_o,
    output exec_unit_e        disp_unit_o,
    output exec_op_e          disp_op_o,     // Ungated copy for retire
    output exec_op_e          alu_op_o,
    output exec_op_e          br_op_o,
    output exec_op_e          mem_op_o,
    output logic [XLEN-1:0]   disp_npc_o,
    output logic [XLEN-1:0]   disp_opa_o,
    output logic [XLEN-1:0]   disp_opb_o,
    output logic [XLEN-1:0]   disp_opc_o,
    output logic [TAG_W-1:0]  disp_tag_o
);

    exec_unit_e unit_dec;   // Unit of the incoming opcode
    logic       load;       // Input transfer

    always_comb begin
        case (in_op_i)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
            OP_AND, OP_OR, OP_XOR,
            OP_SLL, OP_SRL, OP_SRA:          unit_dec = UNIT_ALU;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
            OP_JAL:                          unit_dec = UNIT_BRANCH;
            OP_LW, OP_LB, OP_SW, OP_SB:      unit_dec = UNIT_MEM;
            default:                         unit_dec = UNIT_BYPASS;  // MOV, NOP
        endcase
    end

    assign in_ready_o = !disp_valid_o || advance_i;  // Empty or draining
    assign load       = in_valid_i && in_ready_o;

    ////////////////////////////////
    // Pipeline register
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            disp_valid_o <= 1'b0;
            disp_unit_o  <= UNIT_BYPASS;
            disp_op_o    <= OP_NOP;
        end else if (load) begin
            disp_valid_o <= 1'b1;
            disp_unit_o  <= unit_dec;
            disp_op_o    <= in_op_i;
        end else if (advance_i) begin
            disp_valid_o <= 1'b0;   // Entry moved on with nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin             // Operands and tag
            disp_npc_o <= in_npc_i;
            disp_opa_o <= in_opa_i;
            disp_opb_o <= in_opb_i;
            disp_opc_o <= in_opc_i;
            disp_tag_o <= in_tag_i;
        end
    end

    // Idle units see NOP
    assign alu_op_o = (disp_valid_o && disp_unit_o == UNIT_ALU)    ? disp_op_o : OP_NOP;
    assign br_op_o  = (disp_valid_o && disp_unit_o == UNIT_BRANCH) ? disp_op_o : OP_NOP;
    assign mem_op_o = (disp_valid_o && disp_unit_o == UNIT_MEM)    ? disp_op_o : OP_NOP;

endmodule

/* src/exec_alu.sv */
module exec_alu import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input  exec_op_e         op_i,      // Gated opcode
    input  logic [XLEN-1:0]  opa_i,
    input  logic [XLEN-1:0]  opb_i,
    output logic [XLEN-1:0]  result_o
);

    logic [SHAMT_W-1:0] shamt;      // Low bits of opb
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    diff;
    logic               lt_s;       // Signed less-than
    logic               lt_u;       // Unsigned less-than

    assign shamt = opb_i[SHAMT_W-1:0];

    ////////////////////////////////
    // Adder and comparators
    ////////////////////////////////
    assign sum  = opa_i + opb_i;
    assign diff = opa_i - opb_i;
    assign lt_s = $signed(opa_i) < $signed(opb_i);
    assign lt_u = opa_i < opb_i;

    ////////////////////////////////
    // Result select
    ////////////////////////////////
    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = sum;
            end
            OP_SUB: begin
                result_o = diff;
            end
            OP_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s};    // 0 or 1
            end
            OP_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            OP_AND: begin
                result_o = opa_i & opb_i;
            end
            OP_OR: begin
                result_o = opa_i | opb_i;
            end
            OP_XOR: begin
                result_o = opa_i ^ opb_i;
            end
            OP_SLL: begin
                result_o = opa_i << shamt;
            end
            OP_SRL: begin
                result_o = opa_i >> shamt;              // Zero fill
            end
            OP_SRA: begin
                result_o = $unsigned($signed(opa_i) >>> shamt);  // Sign fill
            end
            default: begin
                result_o = '0;                          // Not an ALU op
            end
        endcase
    end

endmodule

/* src/exec_branch.sv */
module exec_branch import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input  exec_op_e         op_i,      // Gated opcode
    input  logic [XLEN-1:0]  npc_i,     // Address of next instruction
    input  logic [XLEN-1:0]  opa_i,
    input  logic [XLEN-1:0]  opb_i,
    input  logic [XLEN-1:0]  opc_i,     // Offset
    output logic             taken_o,
    output logic [XLEN-1:0]  target_o,
    output logic [XLEN-1:0]  link_o,
    output logic             rf_we_o    // Only JAL writes back
);

    logic             eq;
    logic             lt;               // Signed
    logic [XLEN-1:0]  pc;               // Branch's own pc

    assign eq = opa_i == opb_i;
    assign lt = $signed(opa_i) < $signed(opb_i);
    assign pc = npc_i - XLEN'(INSN_BYTES);

    ////////////////////////////////
    // Condition and target
    ////////////////////////////////
    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        link_o   = '0;
        rf_we_o  = 1'b0;
        case (op_i)
            OP_BEQ: begin
                taken_o  = eq;
                target_o = pc + opc_i;
            end
            OP_BNE: begin
                taken_o  = !eq;
                target_o = pc + opc_i;
            end
            OP_BLT: begin
                taken_o  = lt;
                target_o = pc + opc_i;
            end
            OP_BGE: begin
                taken_o  = !lt;         // Signed greater or equal
                target_o = pc + opc_i;
            end
            OP_JAL: begin
                taken_o  = 1'b1;        // Always jumps
                target_o = opa_i + opc_i;
                link_o   = npc_i;       // Return address
                rf_we_o  = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* src/exec_mem_addr.sv */
module exec_mem_addr import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input  exec_op_e         op_i,      // Gated opcode
    input  logic [XLEN-1:0]  opa_i,     // Base
    input  logic [XLEN-1:0]  opb_i,     // Store data
    input  logic [XLEN-1:0]  opc_i,     // Offset
    output logic [XLEN-1:0]  addr_o,
    output logic [XLEN-1:0]  wdata_o,
    output logic [BE_W-1:0]  be_o,
    output logic             read_o,
    output logic             rf_we_o
);

    localparam int OFS_W = $clog2(BE_W);    // Byte offset bits

    logic [XLEN-1:0]  ea;                   // Effective address
    logic [OFS_W-1:0] ofs;

    assign ea  = opa_i + opc_i;
    assign ofs = ea[OFS_W-1:0];

    ////////////////////////////////
    // Access decode
    ////////////////////////////////
    always_comb begin
        addr_o  = '0;
        wdata_o = '0;
        be_o    = '0;
        read_o  = 1'b0;
        rf_we_o = 1'b0;
        case (op_i)
            OP_LW, OP_LB: begin
                addr_o  = ea;
                read_o  = 1'b1;
                rf_we_o = 1'b1;         // Load result goes to register
            end
            OP_SW: begin
                addr_o  = ea;
                wdata_o = opb_i;
                be_o    = '1;           // Whole word
            end
            OP_SB: begin
                addr_o  = ea;
                wdata_o = {BE_W{opb_i[BYTE_W-1:0]}};   // Byte in every lane
                be_o    = BE_W'(1) << ofs;             // One lane
            end
            default: begin
            end
        endcase
    end

endmodule

/* src/exec_retire.sv */
module exec_retire import exec_isa_pkg::*, exec_pipe_pkg::*; #(
    parameter int TAG_W = TAG_W_DEF
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              disp_valid_i,
    input  exec_unit_e        disp_unit_i,
    input  exec_op_e          disp_op_i,
    input  logic [TAG_W-1:0]  disp_tag_i,
    input  logic [XLEN-1:0]   bypass_i,       // Operand B for MOV
    input  logic [XLEN-1:0]   alu_result_i,
    input  logic              br_taken_i,
    input  logic [XLEN-1:0]   br_target_i,
    input  logic [XLEN-1:0]   br_link_i,
    input  logic              br_rf_we_i,
    input  logic [XLEN-1:0]   mem_addr_i,
    input  logic [XLEN-1:0]   mem_wdata_i,
    input  logic [BE_W-1:0]   mem_be_i,
    input  logic              mem_read_i,
    input  logic              mem_rf_we_i,
    input  logic              out_ready_i,
    output logic              advance_o,      // Output register can load
    output logic              out_valid_o,
    output logic [XLEN-1:0]   out_result_o,
    output logic [XLEN-1:0]   out_target_o,
    output logic              out_jump_o,
    output logic              out_rf_we_o,
    output logic              out_mem_read_o,
    output logic [BE_W-1:0]   out_mem_be_o,
    output logic [TAG_W-1:0]  out_tag_o
);

    logic [XLEN-1:0] nxt_result;
    logic [XLEN-1:0] nxt_target;
    logic            nxt_jump;
    logic            nxt_rf_we;
    logic            nxt_read;
    logic [BE_W-1:0] nxt_be;

    assign advance_o = !out_valid_o || out_ready_i;   // Empty or taken

    ////////////////////////////////
    // Field demux
    ////////////////////////////////
    always_comb begin
        nxt_result = '0;
        nxt_target = '0;
        nxt_jump   = 1'b0;
        nxt_rf_we  = 1'b0;
        nxt_read   = 1'b0;
        nxt_be     = '0;
        case (disp_unit_i)
            UNIT_ALU: begin
                nxt_result = alu_result_i;
                nxt_rf_we  = 1'b1;
            end
            UNIT_BRANCH: begin
                nxt_result = br_link_i;     // Zero unless JAL
                nxt_target = br_target_i;
                nxt_jump   = br_taken_i;
                nxt_rf_we  = br_rf_we_i;
            end
            UNIT_MEM: begin
                nxt_result = mem_wdata_i;   // Zero for loads
                nxt_target = mem_addr_i;
                nxt_read   = mem_read_i;
                nxt_be     = mem_be_i;
                nxt_rf_we  = mem_rf_we_i;
            end
            default: begin                  // MOV passes opb and NOP leaves all low
                if (disp_op_i == OP_MOV) begin
                    nxt_result = bypass_i;
                    nxt_rf_we  = 1'b1;
                end
            end
        endcase
    end

    ////////////////////////////////
    // Output register
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o    <= 1'b0;
            out_jump_o     <= 1'b0;
            out_rf_we_o    <= 1'b0;
            out_mem_read_o <= 1'b0;
            out_mem_be_o   <= '0;
        end else if (advance_o) begin
            out_valid_o    <= disp_valid_i;
            out_jump_o     <= disp_valid_i && nxt_jump;    // Controls low when empty
            out_rf_we_o    <= disp_valid_i && nxt_rf_we;
            out_mem_read_o <= disp_valid_i && nxt_read;
            out_mem_be_o   <= disp_valid_i ? nxt_be : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin                // Payload holds while stalled
            out_result_o <= nxt_result;
            out_target_o <= nxt_target;
            out_tag_o    <= disp_tag_i;
        end
    end

endmodule

/* src/exec_unit.sv */
module exec_unit import exec_isa_pkg::*, exec_pipe_pkg::*; #(
    parameter int TAG_W = TAG_W_DEF
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              in_valid_i,
    input  exec_op_e          in_op_i,
    input  logic [XLEN-1:0]   in_npc_i,
    input  logic [XLEN-1:0]   in_opa_i,
    input  logic [XLEN-1:0]   in_opb_i,
    input  logic [XLEN-1:0]   in_opc_i,
    input  logic [TAG_W-1:0]  in_tag_i,
    output logic              in_ready_o,
    input  logic              out_ready_i,
    output logic              out_valid_o,
    output logic [XLEN-1:0]   out_result_o,
    output logic [XLEN-1:0]   out_target_o,
    output logic              out_jump_o,
    output logic              out_rf_we_o,
    output logic              out_mem_read_o,
    output logic [BE_W-1:0]   out_mem_be_o,
    output logic [TAG_W-1:0]  out_tag_o
);

    logic              advance;
    logic              disp_valid;
    exec_unit_e        disp_unit;
    exec_op_e          disp_op, alu_op, br_op, mem_op;
    logic [XLEN-1:0]   disp_npc, disp_opa, disp_opb, disp_opc;
    logic [TAG_W-1:0]  disp_tag;
    logic [XLEN-1:0]   alu_result, br_target, br_link, mem_addr, mem_wdata;
    logic              br_taken, br_rf_we, mem_read, mem_rf_we;
    logic [BE_W-1:0]   mem_be;

    ////////////////////////////////
    // Dispatch and units
    ////////////////////////////////
    exec_dispatch #(.TAG_W(TAG_W)) u_dispatch (
        .clk(clk), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_op_i(in_op_i), .in_npc_i(in_npc_i),
        .in_opa_i(in_opa_i), .in_opb_i(in_opb_i), .in_opc_i(in_opc_i),
        .in_tag_i(in_tag_i), .advance_i(advance), .in_ready_o(in_ready_o),
        .disp_valid_o(disp_valid), .disp_unit_o(disp_unit), .disp_op_o(disp_op),
        .alu_op_o(alu_op), .br_op_o(br_op), .mem_op_o(mem_op),
        .disp_npc_o(disp_npc), .disp_opa_o(disp_opa), .disp_opb_o(disp_opb),
        .disp_opc_o(disp_opc), .disp_tag_o(disp_tag)
    );

    exec_alu u_alu (
        .op_i(alu_op), .opa_i(disp_opa), .opb_i(disp_opb), .result_o(alu_result)
    );

    exec_branch u_branch (
        .op_i(br_op), .npc_i(disp_npc), .opa_i(disp_opa), .opb_i(disp_opb),
        .opc_i(disp_opc), .taken_o(br_taken), .target_o(br_target),
        .link_o(br_link), .rf_we_o(br_rf_we)
    );

    exec_mem_addr u_mem_addr (
        .op_i(mem_op), .opa_i(disp_opa), .opb_i(disp_opb), .opc_i(disp_opc),
        .addr_o(mem_addr), .wdata_o(mem_wdata), .be_o(mem_be),
        .read_o(mem_read), .rf_we_o(mem_rf_we)
    );

    ////////////////////////////////
    // Retire
    ////////////////////////////////
    exec_retire #(.TAG_W(TAG_W)) u_retire (
        .clk(clk), .rst_i(rst_i),
        .disp_valid_i(disp_valid), .disp_unit_i(disp_unit), .disp_op_i(disp_op),
        .disp_tag_i(disp_tag), .bypass_i(disp_opb), .alu_result_i(alu_result),
        .br_taken_i(br_taken), .br_target_i(br_target), .br_link_i(br_link),
        .br_rf_we_i(br_rf_we), .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
        .mem_be_i(mem_be), .mem_read_i(mem_read), .mem_rf_we_i(mem_rf_we),
        .out_ready_i(out_ready_i), .advance_o(advance), .out_valid_o(out_valid_o),
        .out_result_o(out_result_o), .out_target_o(out_target_o),
        .out_jump_o(out_jump_o), .out_rf_we_o(out_rf_we_o),
        .out_mem_read_o(out_mem_read_o), .out_mem_be_o(out_mem_be_o),
        .out_tag_o(out_tag_o)
    );

endmodule

/* verification/exec_checker.sv */
module exec_checker import exec_pipe_pkg::*; #(
    parameter int TAG_W = TAG_W_DEF
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              out_ready_i,
    input  logic              out_valid_o,
    input  logic [XLEN-1:0]   out_result_o,
    input  logic [XLEN-1:0]   out_target_o,
    input  logic              out_jump_o,
    input  logic              out_rf_we_o,
    input  logic              out_mem_read_o,
    input  logic [BE_W-1:0]   out_mem_be_o,
    input  logic [TAG_W-1:0]  out_tag_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // Assertion failures so far

    //////////////////////////////
    // Output register rules
    //////////////////////////////
    assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o)
            && $stable(out_target_o) && $stable(out_jump_o) && $stable(out_rf_we_o)
            && $stable(out_mem_read_o) && $stable(out_mem_be_o) && $stable(out_tag_o))
    else begin
        fail_cnt++;
        $error("Output changed while stalled");
    end

    assert property (@(posedge clk) disable iff (rst_i)
        !out_valid_o |-> !(out_jump_o || out_rf_we_o || out_mem_read_o || |out_mem_be_o))
    else begin
        fail_cnt++;
        $error("Control set without valid");
    end

    assert property (@(posedge clk) disable iff (rst_i) !(out_mem_read_o && |out_mem_be_o))
    else begin
        fail_cnt++;
        $error("Load with byte enables set");
    end

    assert property (@(posedge clk) disable iff (rst_i) !(out_jump_o && out_mem_read_o))
    else begin
        fail_cnt++;
        $error("Jump together with memory read");
    end

endmodule

bind exec_retire exec_checker #(.TAG_W(TAG_W)) u_checker (.*);

/* verification/exec_tb.sv */
module exec_tb import exec_isa_pkg::*, exec_pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAG_W       = TAG_W_DEF;
    localparam int N_ALU       = 40;
    localparam int N_BR        = 20;    // Random branches after the directed ones
    localparam int N_MEM       = 12;
    localparam int N_MIX       = 60;
    localparam int N_OPS       = 1 + N_ALU + 5 + N_BR + 7 + N_MEM + 2 + N_MIX;
    localparam int CYCLE_LIMIT = N_OPS * 4 + 100;

    typedef struct packed {
        logic [XLEN-1:0]  result;
        logic [XLEN-1:0]  target;
        logic             jump;
        logic             rf_we;
        logic             mem_read;
        logic [BE_W-1:0]  be;
        logic [TAG_W-1:0] tag;
    } expect_t;

    logic              clk;
    logic              rst_i;
    logic              in_valid_i;
    exec_op_e          in_op_i;
    logic [XLEN-1:0]   in_npc_i;
    logic [XLEN-1:0]   in_opa_i;
    logic [XLEN-1:0]   in_opb_i;
    logic [XLEN-1:0]   in_opc_i;
    logic [TAG_W-1:0]  in_tag_i;
    logic              in_ready_o;
    logic              out_ready_i;
    logic              out_valid_o;
    logic [XLEN-1:0]   out_result_o;
    logic [XLEN-1:0]   out_target_o;
    logic              out_jump_o;
    logic              out_rf_we_o;
    logic              out_mem_read_o;
    logic [BE_W-1:0]   out_mem_be_o;
    logic [TAG_W-1:0]  out_tag_o;

    expect_t           exp_q[$];        // Accepted, not yet retired
    int                seed = 95601;
    int                err_cnt = 0;
    int                test_cnt = 0;
    int                test_fail = 0;
    int                cycles = 0;
    logic              ready_random;    // Back-pressure on
    logic [TAG_W-1:0]  tag_cnt;

    exec_unit #(.TAG_W(TAG_W)) u_exec_unit (
        .clk(clk), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_op_i(in_op_i), .in_npc_i(in_npc_i),
        .in_opa_i(in_opa_i), .in_opb_i(in_opb_i), .in_opc_i(in_opc_i),
        .in_tag_i(in_tag_i), .in_ready_o(in_ready_o), .out_ready_i(out_ready_i),
        .out_valid_o(out_valid_o), .out_result_o(out_result_o),
        .out_target_o(out_target_o), .out_jump_o(out_jump_o),
        .out_rf_we_o(out_rf_we_o), .out_mem_read_o(out_mem_read_o),
        .out_mem_be_o(out_mem_be_o), .out_tag_o(out_tag_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic expect_t exec_model(exec_op_e op, logic [XLEN-1:0] npc,
        logic [XLEN-1:0] opa, logic [XLEN-1:0] opb, logic [XLEN-1:0] opc,
        logic [TAG_W-1:0] tag);
        expect_t          e;
        logic [XLEN-1:0]  ea;
        e     = '0;
        e.tag = tag;
        ea    = opa + opc;                                  // Memory address
        case (op)
            OP_ADD:  e.result = opa + opb;
            OP_SUB:  e.result = opa - opb;
            OP_SLT:  e.result = ($signed(opa) < $signed(opb)) ? 1 : 0;
            OP_SLTU: e.result = (opa < opb) ? 1 : 0;
            OP_AND:  e.result = opa & opb;
            OP_OR:   e.result = opa | opb;
            OP_XOR:  e.result = opa ^ opb;
            OP_SLL:  e.result = opa << opb[4:0];
            OP_SRL:  e.result = opa >> opb[4:0];
            OP_SRA:  e.result = $signed(opa) >>> opb[4:0];
            OP_BEQ:  e.jump = (opa == opb);
            OP_BNE:  e.jump = (opa != opb);
            OP_BLT:  e.jump = ($signed(opa) < $signed(opb));
            OP_BGE:  e.jump = ($signed(opa) >= $signed(opb));
            OP_JAL: begin
                e.result = npc;                             // Link
                e.jump   = 1'b1;
                e.target = opa + opc;
            end
            OP_LW, OP_LB: begin
                e.target   = ea;
                e.mem_read = 1'b1;
            end
            OP_SW: begin
                e.target = ea;
                e.result = opb;
                e.be     = 4'b1111;
            end
            OP_SB: begin
                e.target = ea;
                e.result = {4{opb[7:0]}};                   // Byte in each lane
                e.be     = 4'b0001 << ea[1:0];
            end
            OP_MOV:  e.result = opb;
            default: e.result = '0;                         // NOP
        endcase
        if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE}) begin
            e.target = npc - 4 + opc;                       // Relative to own pc
        end
        e.rf_we = (op inside {OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
                              OP_SLL, OP_SRL, OP_SRA, OP_JAL, OP_LW, OP_LB, OP_MOV});
        return e;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_be(string name, logic [BE_W-1:0] got, logic [BE_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_tag(string name, logic [TAG_W-1:0] got, logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    //////////////////////////////
    // Scoreboard and limits
    //////////////////////////////
    always @(posedge clk) begin
        if (!rst_i && in_valid_i && in_ready_o) begin          // Input transfer
            exp_q.push_back(exec_model(in_op_i, in_npc_i, in_opa_i, in_opb_i, in_opc_i,
                                       in_tag_i));
        end
    end

    always @(posedge clk) begin
        expect_t e;
        if (!rst_i && out_valid_o && out_ready_i) begin        // Output transfer
            if (exp_q.size() == 0) begin
                $display("Output transfer at %0t ns with no operation outstanding", $time);
                err_cnt++;
            end else begin
                e = exp_q.pop_front();
                check_tag("out_tag_o", out_tag_o, e.tag);   // Order kept
                check_word("out_result_o", out_result_o, e.result);
                check_word("out_target_o", out_target_o, e.target);
                check_bit("out_jump_o", out_jump_o, e.jump);
                check_bit("out_rf_we_o", out_rf_we_o, e.rf_we);
                check_bit("out_mem_read_o", out_mem_read_o, e.mem_read);
                check_be("out_mem_be_o", out_mem_be_o, e.be);
            end
        end
    end

    always @(negedge clk) begin
        out_ready_i = ready_random ? 1'($random(seed)) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, operations did not come out", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////
    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic send_op(exec_op_e op, logic [XLEN-1:0] opa, logic [XLEN-1:0] opb,
        logic [XLEN-1:0] opc);
        @(negedge clk);
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_npc_i   = rand_word() & 32'hffff_fffc;           // Word aligned
        in_opa_i   = opa;
        in_opb_i   = opb;
        in_opc_i   = opc;
        in_tag_i   = tag_cnt;
        do @(posedge clk); while (!in_ready_o);             // Hold until taken
        tag_cnt++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic end_test(string name, int err_start);
        test_cnt++;
        if (err_cnt != err_start) test_fail++;
        $display("Test %0d %s finished with %0d errors", test_cnt, name, err_cnt - err_start);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int               e0;
        int               i;
        int               lat;
        exec_op_e         op;
        logic [XLEN-1:0]  a;
        rst_i        = 1'b1;
        in_valid_i   = 1'b0;
        in_op_i      = OP_NOP;
        in_npc_i     = '0;
        in_opa_i     = '0;
        in_opb_i     = '0;
        in_opc_i     = '0;
        in_tag_i     = '0;
        out_ready_i  = 1'b1;
        ready_random = 1'b0;
        tag_cnt      = '0;
        repeat (4) @(negedge clk);
        rst_i = 1'b0;

        e0 = err_cnt;                                       // Reset state and latency
        check_bit("in_ready_o", in_ready_o, 1'b1);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("out_jump_o", out_jump_o, 1'b0);
        check_bit("out_rf_we_o", out_rf_we_o, 1'b0);
        check_bit("out_mem_read_o", out_mem_read_o, 1'b0);
        check_be("out_mem_be_o", out_mem_be_o, '0);
        send_op(OP_ADD, 32'd7, 32'd5, 32'd0);
        lat = 0;
        do begin
            idle_cycle();
            lat++;
        end while (!out_valid_o && lat < 10);
        if (lat != 2) begin
            $display("Error at %0t ns: ADD took %0d cycles, expected 2", $time, lat);
            err_cnt++;
        end
        drain();
        end_test("reset and latency", e0);

        e0 = err_cnt;
        for (i = 0; i < N_ALU; i++) begin                   // Every ALU op in turn
            op = exec_op_e'(5'(int'(OP_ADD) + i % 10));
            send_op(op, rand_word(), rand_word(), rand_word());
        end
        drain();
        end_test("ALU operations", e0);

        e0 = err_cnt;
        send_op(OP_BLT, -32'sd5, 32'd3, 32'h40);            // Negative below positive
        send_op(OP_BGE, -32'sd5, 32'd3, 32'h40);
        send_op(OP_BGE, 32'd3, -32'sd5, -32'sd16);
        send_op(OP_BEQ, 32'h1234, 32'h1234, -32'sd8);
        send_op(OP_JAL, 32'h1000, 32'd0, 32'h20);
        for (i = 0; i < N_BR; i++) begin
            op = exec_op_e'(5'(int'(OP_BEQ) + i % 5));
            a  = rand_word();
            send_op(op, a, (i % 3 == 0) ? a : rand_word(), rand_word());
        end
        drain();
        end_test("branches and jumps", e0);

        e0 = err_cnt;
        for (i = 0; i < 4; i++) begin
            send_op(OP_SB, 32'h2000, rand_word(), i);      // Each byte offset
        end
        send_op(OP_LW, 32'h3000, rand_word(), 32'h10);
        send_op(OP_LB, 32'h3000, rand_word(), 32'h13);
        send_op(OP_SW, 32'h3000, rand_word(), 32'h14);
        for (i = 0; i < N_MEM; i++) begin
            op = exec_op_e'(5'(int'(OP_LW) + i % 4));
            send_op(op, rand_word(), rand_word(), rand_word());
        end
        drain();
        end_test("loads and stores", e0);

        e0 = err_cnt;
        ready_random = 1'b1;
        send_op(OP_MOV, rand_word(), rand_word(), rand_word());
        send_op(OP_NOP, rand_word(), rand_word(), rand_word());
        for (i = 0; i < N_MIX; i++) begin
            if (rand_word() % 4 == 0) idle_cycle();         // Gap in input valid
            op = exec_op_e'(5'(rand_word() % 21));
            send_op(op, rand_word(), rand_word(), rand_word());
        end
        drain();
        ready_random = 1'b0;
        end_test("mixed stream with back-pressure", e0);

        err_cnt += u_exec_unit.u_retire.u_checker.fail_cnt;
        $display("Tests run: %0d, tests failed: %0d, errors: %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* project.f */
src/exec_isa_pkg.sv
src/exec_pipe_pkg.sv
src/exec_dispatch.sv
src/exec_alu.sv
src/exec_branch.sv
src/exec_mem_addr.sv
src/exec_retire.sv
src/exec_unit.sv
verification/exec_checker.sv
verification/exec_tb.sv
